/* rtl/ahbApbPkg.sv */
// Bridge package with controller states, AHB transfer types and the APB address map
package ahbApbPkg;

	// Bus widths
	localparam int unsigned AddrW = 32;
	localparam int unsigned DataW = 32;

	// Number of APB peripherals, one Pselx bit each
	localparam int unsigned SelW = 3;

	// Address map
	localparam logic [AddrW-1:0] MapBase    = 32'h8000_0000;
	localparam logic [AddrW-1:0] RegionSize = 32'h0400_0000; // One region per peripheral

	// APB controller states
	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stRenable  = 3'b101,
		stWenable  = 3'b110,
		stWenableP = 3'b111
	} apbStateT;

	// AHB Htrans encoding
	typedef enum logic [1:0]
	{
		transIdle   = 2'b00,
		transBusy   = 2'b01,
		transNonseq = 2'b10,
		transSeq    = 2'b11
	} htransT;

endpackage

/* rtl/ahbPipeIf.sv */
// Interface for decoded and pipelined AHB transfer info, slave and ctrl modports
`timescale 1ns/1ps

interface ahbPipeIf import ahbApbPkg::*; ();

	logic             valid;    // Accepted AHB transfer in address phase
	logic [AddrW-1:0] addr0;
	logic [AddrW-1:0] addr1;
	logic [AddrW-1:0] addr2;
	logic [DataW-1:0] wdata1;
	logic             writeReg;
	logic [SelW-1:0]  tempSelx; // One-hot region of addr0

	modport slave
	(
		output valid, addr0, addr1, addr2, wdata1, writeReg, tempSelx
	);

	modport ctrl
	(
		input valid, addr0, addr1, addr2, wdata1, writeReg, tempSelx
	);

endinterface

/* rtl/ahbSlaveInterface.sv */
// AHB slave side with address decode, valid generation and address/data pipeline
`timescale 1ns/1ps

module ahbSlaveInterface import ahbApbPkg::*;
(
	input  logic             Hclk,
	input  logic             Hresetn,
	input  logic             Hwrite,
	input  logic             Hreadyin,
	input  htransT           Htrans,
	input  logic [AddrW-1:0] Haddr,
	input  logic [DataW-1:0] Hwdata,
	ahbPipeIf.slave          pipe
);

	logic [AddrW-1:0] offset;
	logic [SelW-1:0]  regionSel;
	logic             inMap;
	logic             activeTrans;

	// Addresses below MapBase wrap to an offset far past the map
	assign offset = Haddr - MapBase;

	always_comb
	begin
		regionSel = '0;
		for (int i = 0; i < SelW; i++)
		begin
			if ((offset >= AddrW'(i) * RegionSize) && (offset < AddrW'(i + 1) * RegionSize))
				regionSel[i] = 1'b1;
		end
	end

	assign inMap = |regionSel;

	// Idle and busy cycles carry no transfer
	assign activeTrans = (Htrans == transNonseq) || (Htrans == transSeq);

	assign pipe.valid    = Hreadyin && activeTrans && inMap;
	assign pipe.tempSelx = regionSel;
	assign pipe.addr0    = Haddr;

	// Address, data and direction delayed for the write data phase
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			pipe.addr1    <= '0;
			pipe.addr2    <= '0;
			pipe.wdata1   <= '0;
			pipe.writeReg <= 1'b0;
		end
		else
		begin
			pipe.addr1    <= Haddr;
			pipe.addr2    <= pipe.addr1;
			pipe.wdata1   <= Hwdata;   // Data of a transfer held in its data phase
			pipe.writeReg <= Hwrite;
		end
	end

endmodule

/* rtl/apbFsmController.sv */
// APB transfer FSM with next-state logic, output decode and registered APB outputs
`timescale 1ns/1ps

module apbFsmController import ahbApbPkg::*;
(
	input  logic             Hclk,
	input  logic             Hresetn,
	input  logic             Hwrite,
	input  logic [DataW-1:0] Hwdata,
	ahbPipeIf.ctrl           pipe,
	output logic             Pwrite,
	output logic             Penable,
	output logic             Hreadyout,
	output logic [SelW-1:0]  Pselx,
	output logic [AddrW-1:0] Paddr,
	output logic [DataW-1:0] Pwdata
);

	apbStateT state;
	apbStateT nextState;

	logic             pwriteNext;
	logic             penableNext;
	logic             hreadyNext;
	logic [SelW-1:0]  pselxNext;
	logic [AddrW-1:0] paddrNext;
	logic [DataW-1:0] pwdataNext;

	// Region selects lined up with addr1 and addr2
	logic [SelW-1:0]  selDly1;
	logic [SelW-1:0]  selDly2;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= stIdle;
		else
			state <= nextState;
	end

	// In stWenableP the stall flag tells the type of the pending transfer.
	// A pending write lets the master go on, a pending read keeps it waiting.
	always_comb
	begin
		nextState = state;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				if (!pipe.valid)
					nextState = stIdle;
				else if (Hwrite)
					nextState = stWwait;
				else
					nextState = stRead;
			end

			stWwait:
			begin
				if (pipe.valid)
					nextState = stWriteP; // Second transfer while the first is queued
				else
					nextState = stWrite;
			end

			stRead:
				nextState = stRenable;

			stWrite:
				nextState = stWenable;

			stWriteP:
				nextState = stWenableP;

			stWenableP:
			begin
				if (!Hreadyout)
					nextState = stRead;
				else if (pipe.valid)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end

			default:
				nextState = stIdle;
		endcase
	end

	always_comb
	begin
		pselxNext   = Pselx;
		penableNext = Penable;
		pwriteNext  = Pwrite;
		hreadyNext  = Hreadyout;
		paddrNext   = Paddr;
		pwdataNext  = Pwdata;

		case (state)
			stIdle, stRenable, stWenable:
			begin
				penableNext = 1'b0;
				if (pipe.valid && !Hwrite)
				begin
					// Read setup straight from the address phase
					pselxNext  = pipe.tempSelx;
					paddrNext  = pipe.addr0;
					pwriteNext = 1'b0;
					hreadyNext = 1'b0;
				end
				else
				begin
					pselxNext  = '0;
					hreadyNext = 1'b1; // Write data phase or idle
				end
			end

			stWwait:
			begin
				pselxNext   = selDly1;
				paddrNext   = pipe.addr1;
				pwdataNext  = Hwdata;
				pwriteNext  = 1'b1;
				penableNext = 1'b0;
				hreadyNext  = 1'b0;
			end

			stRead, stWrite:
			begin
				penableNext = 1'b1;
				hreadyNext  = 1'b1;
			end

			stWriteP:
			begin
				penableNext = 1'b1;
				hreadyNext  = pipe.writeReg; // Hold off a pending read
			end

			stWenableP:
			begin
				// Launch the transfer accepted during the previous write
				pselxNext   = selDly2;
				paddrNext   = pipe.addr2;
				pwdataNext  = pipe.wdata1;
				pwriteNext  = Hreadyout;
				penableNext = 1'b0;
				hreadyNext  = 1'b0;
			end

			default:
			begin
				pselxNext   = '0;
				penableNext = 1'b0;
				hreadyNext  = 1'b1;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Pselx     <= '0;
			Penable   <= 1'b0;
			Pwrite    <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			Pselx     <= pselxNext;
			Penable   <= penableNext;
			Pwrite    <= pwriteNext;
			Hreadyout <= hreadyNext;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr   <= paddrNext;
		Pwdata  <= pwdataNext;
		selDly1 <= pipe.tempSelx;
		selDly2 <= selDly1;
	end

endmodule

/* rtl/ahbApbBridge.sv */
// Top level AHB-Lite to APB bridge joining the AHB slave side and the APB controller
`timescale 1ns/1ps

module ahbApbBridge import ahbApbPkg::*;
(
	input  logic             Hclk,
	input  logic             Hresetn,
	input  logic             Hwrite,
	input  logic             Hreadyin,
	input  logic [1:0]       Htrans,
	input  logic [AddrW-1:0] Haddr,
	input  logic [DataW-1:0] Hwdata,
	input  logic [DataW-1:0] Prdata,
	output logic             Hreadyout,
	output logic             Pwrite,
	output logic             Penable,
	output logic [SelW-1:0]  Pselx,
	output logic [AddrW-1:0] Paddr,
	output logic [DataW-1:0] Pwdata,
	output logic [DataW-1:0] Hrdata
);

	ahbPipeIf pipe();

	ahbSlaveInterface ahbSide
	(
		.Hclk     (Hclk),
		.Hresetn  (Hresetn),
		.Hwrite   (Hwrite),
		.Hreadyin (Hreadyin),
		.Htrans   (htransT'(Htrans)),
		.Haddr    (Haddr),
		.Hwdata   (Hwdata),
		.pipe     (pipe.slave)
	);

	apbFsmController apbSide
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Hwrite    (Hwrite),
		.Hwdata    (Hwdata),
		.pipe      (pipe.ctrl),
		.Pwrite    (Pwrite),
		.Penable   (Penable),
		.Hreadyout (Hreadyout),
		.Pselx     (Pselx),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata)
	);

	// Read data is valid in the APB access cycle
	assign Hrdata = Prdata;

endmodule

/* tb/apbSlaveModel.sv */
// APB slave model with three memory regions, read data return and a write log
`timescale 1ns/1ps

module apbSlaveModel import ahbApbPkg::*;
(
	input  logic             Hclk,
	input  logic [SelW-1:0]  Pselx,
	input  logic             Penable,
	input  logic             Pwrite,
	input  logic [AddrW-1:0] Paddr,
	input  logic [DataW-1:0] Pwdata,
	output logic [DataW-1:0] Prdata
);

	localparam int unsigned Words = 256; // Words per region, byte address bits 9:2

	logic [DataW-1:0] mem [SelW][Words];

	// Completed writes in the order they finished on APB
	int unsigned      writeCount;
	logic [AddrW-1:0] logAddr [$];
	logic [DataW-1:0] logData [$];

	function automatic logic [DataW-1:0] seedWord(input logic [AddrW-1:0] addr);
		return {addr[7:0], addr[31:24], ~addr[15:8], addr[23:16]} ^ 32'h3C5A_A5C3;
	endfunction

	initial
	begin
		logic [AddrW-1:0] addr;
		writeCount = 0;
		for (int r = 0; r < SelW; r++)
		begin
			for (int w = 0; w < Words; w++)
			begin
				addr = MapBase + RegionSize * AddrW'(r) + AddrW'(w * 4);
				mem[r][w] = seedWord(addr);
			end
		end
	end

	always_comb
	begin
		logic [AddrW-1:0] region;
		region = (Paddr - MapBase) / RegionSize;
		if (region < AddrW'(SelW))
			Prdata = mem[region][Paddr[9:2]];
		else
			Prdata = '0; // Outside the map
	end

	// Write lands in the access cycle
	always @(posedge Hclk)
	begin
		if ((Pselx != '0) && Penable && Pwrite)
		begin
			mem[(Paddr - MapBase) / RegionSize][Paddr[9:2]] <= Pwdata;
			logAddr.push_back(Paddr);
			logData.push_back(Pwdata);
			writeCount <= writeCount + 1;
		end
	end

endmodule

/* tb/tbAhbApbBridge.sv */
// Testbench for the AHB to APB bridge with AHB master tasks, reference memory and checks
`timescale 1ns/1ps

module tbAhbApbBridge import ahbApbPkg::*; ();

	logic             Hclk;
	logic             Hresetn;
	logic             Hwrite;
	logic             Hreadyin;
	logic [1:0]       Htrans;
	logic [AddrW-1:0] Haddr;
	logic [DataW-1:0] Hwdata;
	logic [DataW-1:0] Prdata;
	logic             Hreadyout;
	logic             Pwrite;
	logic             Penable;
	logic [SelW-1:0]  Pselx;
	logic [AddrW-1:0] Paddr;
	logic [DataW-1:0] Pwdata;
	logic [DataW-1:0] Hrdata;

	logic [DataW-1:0] shadow [SelW][256]; // Expected APB memory contents
	int unsigned      errors;
	int unsigned      timeouts;

	ahbApbBridge DUT
	(
		.Hclk(Hclk), .Hresetn(Hresetn), .Hwrite(Hwrite), .Hreadyin(Hreadyin),
		.Htrans(Htrans), .Haddr(Haddr), .Hwdata(Hwdata), .Prdata(Prdata),
		.Hreadyout(Hreadyout), .Pwrite(Pwrite), .Penable(Penable), .Pselx(Pselx),
		.Paddr(Paddr), .Pwdata(Pwdata), .Hrdata(Hrdata)
	);

	apbSlaveModel slave
	(
		.Hclk(Hclk), .Pselx(Pselx), .Penable(Penable), .Pwrite(Pwrite),
		.Paddr(Paddr), .Pwdata(Pwdata), .Prdata(Prdata)
	);

	always #20 Hclk = ~Hclk;

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
	endtask

	task automatic reportRule(input string rule);
		errors++;
		$display("Protocol error at %0t: %s", $time, rule);
	endtask

	// Access follows a setup with the same select, address and direction
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> ($past(Pselx) != '0 && !$past(Penable) && $past(Pselx) == Pselx &&
			$past(Paddr) == Paddr && $past(Pwrite) == Pwrite))
		else reportRule("Penable high without a matching setup cycle");

	assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(Pselx))
		else reportRule("Pselx has more than one bit set");

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		(Pselx != '0 && !Penable) |-> !Hreadyout)
		else reportMismatch("Hreadyout", 32'(Hreadyout), 32'h0);

	function automatic logic [DataW-1:0] initialWord(input logic [AddrW-1:0] addr);
		return {addr[7:0], addr[31:24], ~addr[15:8], addr[23:16]} ^ 32'h3C5A_A5C3;
	endfunction

	function automatic int unsigned regionIndex(input logic [AddrW-1:0] addr);
		return (addr - MapBase) / RegionSize;
	endfunction

	function automatic logic [AddrW-1:0] randomAddr();
		int unsigned region;
		int unsigned word;
		region = $urandom % SelW;
		word = $urandom % 256;
		return MapBase + RegionSize * region + AddrW'(word * 4);
	endfunction

	task automatic expectEqual(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else reportMismatch(name, got, exp);
	endtask

	task automatic step();
		@(posedge Hclk);
		#2;
	endtask

	task automatic waitReady();
		int n;
		n = 0;
		while (!Hreadyout && n < 20)
		begin
			step();
			n++;
		end
		if (!Hreadyout)
		begin
			timeouts++;
			$display("Timeout at %0t: Hreadyout stayed low for 20 cycles", $time);
		end
	endtask

	task automatic waitWrites(input int unsigned target);
		int n;
		n = 0;
		while (slave.writeCount < target && n < 20)
		begin
			step();
			n++;
		end
		if (slave.writeCount < target)
		begin
			timeouts++;
			$display("Timeout at %0t: APB write did not complete in 20 cycles", $time);
		end
	endtask

	task automatic checkLog(input int unsigned idx, input logic [AddrW-1:0] addr,
		input logic [DataW-1:0] data);
		expectEqual("logged Paddr", slave.logAddr[idx], addr);
		expectEqual("logged Pwdata", slave.logData[idx], data);
		shadow[regionIndex(addr)][addr[9:2]] = data;
	endtask

	task automatic singleRead(input logic [AddrW-1:0] addr);
		logic [SelW-1:0] expSel;
		expSel = '0;
		expSel[regionIndex(addr)] = 1'b1;
		waitReady();
		Haddr = addr;
		Hwrite = 1'b0;
		Htrans = transNonseq;
		step();
		Htrans = transIdle;
		expectEqual("Pselx", 32'(Pselx), 32'(expSel)); // Setup cycle
		expectEqual("Paddr", Paddr, addr);
		expectEqual("Pwrite", 32'(Pwrite), 32'h0);
		expectEqual("Penable", 32'(Penable), 32'h0);
		step();
		expectEqual("Penable", 32'(Penable), 32'h1);
		expectEqual("Hreadyout", 32'(Hreadyout), 32'h1);
		expectEqual("Hrdata", Hrdata, shadow[regionIndex(addr)][addr[9:2]]);
	endtask

	task automatic singleWrite(input logic [AddrW-1:0] addr, input logic [DataW-1:0] data);
		int unsigned base;
		base = slave.writeCount;
		waitReady();
		Haddr = addr;
		Hwrite = 1'b1;
		Htrans = transNonseq;
		step();
		Hwdata = data; // Data phase
		Htrans = transIdle;
		Hwrite = 1'b0;
		waitWrites(base + 1);
		checkLog(base, addr, data);
		waitReady();
	endtask

	task automatic writePairThenRead(input logic [AddrW-1:0] a1, input logic [DataW-1:0] d1,
		input logic [AddrW-1:0] a2, input logic [DataW-1:0] d2);
		int unsigned base;
		base = slave.writeCount;
		waitReady();
		Haddr = a1;
		Hwrite = 1'b1;
		Htrans = transNonseq;
		step();
		waitReady();
		Hwdata = d1;
		Haddr = a2; // Second address during first data phase
		step();
		Hwdata = d2;
		Htrans = transIdle;
		Hwrite = 1'b0;
		waitReady();
		Htrans = transNonseq; // Read of a2 while the second write is still queued
		step();
		Htrans = transIdle;
		waitReady();
		expectEqual("Penable", 32'(Penable), 32'h1); // Read access cycle
		expectEqual("Pwrite", 32'(Pwrite), 32'h0);
		expectEqual("Paddr", Paddr, a2);
		expectEqual("Hrdata", Hrdata, d2);
		waitWrites(base + 2);
		checkLog(base, a1, d1);
		checkLog(base + 1, a2, d2);
	endtask

	task automatic noTransfer(input logic [1:0] trans, input logic [AddrW-1:0] addr,
		input logic readyIn);
		waitReady();
		Haddr = addr;
		Hwrite = 1'b0;
		Htrans = trans;
		Hreadyin = readyIn;
		for (int i = 0; i < 3; i++)
		begin
			step();
			Htrans = transIdle;
			Hreadyin = 1'b1;
			expectEqual("Pselx", 32'(Pselx), 32'h0);
		end
	endtask

	initial
	begin
		logic [AddrW-1:0] a1;
		logic [AddrW-1:0] a2;
		void'($urandom(60576));
		errors = 0;
		timeouts = 0;
		Hclk = 1'b0;
		Hresetn = 1'b0;
		Hwrite = 1'b0;
		Hreadyin = 1'b1;
		Htrans = transIdle;
		Haddr = '0;
		Hwdata = '0;
		for (int r = 0; r < SelW; r++)
			for (int w = 0; w < 256; w++)
				shadow[r][w] = initialWord(MapBase + RegionSize * AddrW'(r) + AddrW'(w * 4));

		for (int i = 0; i < 8; i++)
		begin
			step();
			expectEqual("Pselx", 32'(Pselx), 32'h0);
			expectEqual("Penable", 32'(Penable), 32'h0);
			expectEqual("Pwrite", 32'(Pwrite), 32'h0);
			expectEqual("Hreadyout", 32'(Hreadyout), 32'h0);
		end
		Hresetn = 1'b1;
		step();
		expectEqual("Pselx", 32'(Pselx), 32'h0);
		expectEqual("Penable", 32'(Penable), 32'h0);
		expectEqual("Pwrite", 32'(Pwrite), 32'h0);
		expectEqual("Hreadyout", 32'(Hreadyout), 32'h1);

		for (int i = 0; i < 4; i++)
			singleRead(randomAddr());

		for (int i = 0; i < 4; i++)
		begin
			a1 = randomAddr();
			singleWrite(a1, $urandom);
			singleRead(a1);
		end

		for (int i = 0; i < 3; i++)
		begin
			a1 = randomAddr();
			a2 = randomAddr();
			writePairThenRead(a1, $urandom, a2, $urandom);
			singleRead(a1);
		end

		noTransfer(transIdle, randomAddr(), 1'b1);
		noTransfer(transBusy, randomAddr(), 1'b1);
		noTransfer(transNonseq, MapBase - 32'd4, 1'b1);
		noTransfer(transNonseq, MapBase + RegionSize * 3, 1'b1);
		noTransfer(transSeq, 32'hFFFF_FFF0, 1'b1);
		noTransfer(transNonseq, randomAddr(), 1'b0); // Hreadyin low

		repeat (4) step();
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* flist.f */
rtl/ahbApbPkg.sv
rtl/ahbPipeIf.sv
rtl/ahbSlaveInterface.sv
rtl/apbFsmController.sv
rtl/ahbApbBridge.sv
tb/apbSlaveModel.sv
tb/tbAhbApbBridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tbAhbApbBridge \
	-f flist.f \
	-o simv

./obj_dir/simv | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
	exit 0
else
	exit 1
fi
